// ==== hdl/activation_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module activation_path import nn_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire layer_t layer,
    input  wire logic   layer_valid,
    output logic        layer_ready,
    input  wire z_vec_t z,
    input  wire logic   z_valid,
    output logic        z_ready,
    output act_vec_t    act,
    output logic        act_valid,
    input  wire logic   act_ready,
    output logic        overflow
);

    act_vec_t act_next;
    logic     ovf_next;
    logic     ovf_q;
    logic     join_fire;

    // layer and z move together once the output register is free
    assign join_fire   = layer_valid && z_valid && (!act_valid || act_ready);
    assign layer_ready = join_fire;
    assign z_ready     = join_fire;

    always_comb begin
        act_next = '0;
        ovf_next = 1'b0;
        for (int i = 0; i < NEURON_NUM; i++) begin
            if (layer == '0) begin
                // input layer sees z directly, so only truncate
                act_next[i] = act_t'(z[i]);
                if (z[i] > ACT_MAX || z[i] < ACT_MIN) begin
                    ovf_next = 1'b1;
                end
            end else begin
                act_next[i] = act_t'((z[i] >>> SIGMOID_SHIFT) + SIGMOID_OFFSET);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            act <= act_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            act_valid <= 1'b0;
            ovf_q     <= 1'b0;
        end else if (join_fire) begin
            act_valid <= 1'b1;
            ovf_q     <= ovf_next;
        end else if (act_ready) begin
            act_valid <= 1'b0;
            ovf_q     <= 1'b0;
        end
    end

    // flag leaves with the vector that caused it
    assign overflow = act_valid && act_ready && ovf_q;

    // the z producer keeps its vector until the join takes it
    z_hold: assert property (@(posedge clk) disable iff (rst)
        z_valid && !z_ready |=> z_valid && $stable(z));

endmodule

`default_nettype wire

// ==== hdl/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

    // network geometry
    localparam int NEURON_NUM       = 4;
    localparam int LAYER_ADDR_WIDTH = 2;
    localparam int LAYER_NUM        = 2 ** LAYER_ADDR_WIDTH;

    // signed cell widths
    localparam int Z_WIDTH      = 10;
    localparam int ACT_WIDTH    = 9;
    localparam int DELTA_WIDTH  = 10;
    localparam int WEIGHT_WIDTH = 16;

    localparam int LEARNING_RATE_SHIFT = 4;

    // hard sigmoid (z >>> 2) + 128 lands in 0..255
    localparam int SIGMOID_SHIFT  = 2;
    localparam int SIGMOID_OFFSET = 128;

    // signed ranges used for overflow and clamping
    localparam int ACT_MAX    = 2 ** (ACT_WIDTH - 1) - 1;
    localparam int ACT_MIN    = -(2 ** (ACT_WIDTH - 1));
    localparam int WEIGHT_MAX = 2 ** (WEIGHT_WIDTH - 1) - 1;
    localparam int WEIGHT_MIN = -(2 ** (WEIGHT_WIDTH - 1));

    typedef logic [LAYER_ADDR_WIDTH-1:0] layer_t;

    typedef logic signed [Z_WIDTH-1:0]      z_cell_t;
    typedef logic signed [ACT_WIDTH-1:0]    act_t;
    typedef logic signed [DELTA_WIDTH-1:0]  delta_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    typedef z_cell_t [NEURON_NUM-1:0] z_vec_t;
    typedef act_t    [NEURON_NUM-1:0] act_vec_t;
    typedef delta_t  [NEURON_NUM-1:0] delta_vec_t;
    // indexed by delta neuron i, then activation neuron j
    typedef weight_t [NEURON_NUM-1:0][NEURON_NUM-1:0] weight_mat_t;

endpackage

`default_nettype wire

// ==== hdl/stream_fork.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fork #(
    parameter type payload_t = logic [7:0],
    parameter int  N_OUT     = 2
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire payload_t         in_data,
    input  wire logic             in_valid,
    output logic                  in_ready,
    output payload_t              out_data [N_OUT],
    output logic [N_OUT-1:0]      out_valid,
    input  wire logic [N_OUT-1:0] out_ready
);

    logic [N_OUT-1:0] has_room;
    logic             in_fire;

    // accept only when every consumer can take a copy
    assign in_ready = &has_room;
    assign in_fire  = in_valid && in_ready;

    for (genvar k = 0; k < N_OUT; k++) begin : g_out
        payload_t   slot [2];
        logic [1:0] count;
        logic       wr_ptr;
        logic       rd_ptr;
        logic       pop;

        assign has_room[k]  = (count != 2'd2);
        assign out_valid[k] = (count != 2'd0);
        assign out_data[k]  = slot[rd_ptr];
        assign pop          = out_valid[k] && out_ready[k];

        always_ff @(posedge clk) begin
            if (in_fire) begin
                slot[wr_ptr] <= in_data;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                count  <= 2'd0;
                wr_ptr <= 1'b0;
                rd_ptr <= 1'b0;
            end else begin
                if (in_fire) begin
                    wr_ptr <= ~wr_ptr;
                end
                if (pop) begin
                    rd_ptr <= ~rd_ptr;
                end
                case ({in_fire, pop})
                    2'b10:   count <= count + 2'd1;
                    2'b01:   count <= count - 2'd1;
                    default: count <= count;
                endcase
            end
        end

        // two entries at most whatever the consumer does
        buffer_bound: assert property (@(posedge clk) disable iff (rst)
            in_fire && !pop |=> count != 2'd0 && count <= 2'd2);
    end

endmodule

`default_nettype wire

// ==== hdl/weight_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_controller import nn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire layer_t      layer_bw,
    input  wire logic        layer_bw_valid,
    output logic             layer_bw_ready,
    input  wire layer_t      layer_fw,
    input  wire logic        layer_fw_valid,
    output logic             layer_fw_ready,
    input  wire z_vec_t      z,
    input  wire logic        z_valid,
    output logic             z_ready,
    input  wire delta_vec_t  delta,
    input  wire logic        delta_valid,
    output logic             delta_ready,
    output weight_mat_t      w_fw,
    output logic             w_fw_valid,
    input  wire logic        w_fw_ready,
    output weight_mat_t      w_bw,
    output logic             w_bw_valid,
    input  wire logic        w_bw_ready,
    output logic             error
);

    // layer copies go to read address (0), write address (1) and activation (2)
    layer_t      layer_copy [3];
    logic [2:0]  layer_copy_valid;
    logic [2:0]  layer_copy_ready;

    // matrix copies go to the updater (0) and w_bw (1)
    weight_mat_t w_copy [2];
    logic [1:0]  w_copy_valid;
    logic [1:0]  w_copy_ready;

    weight_mat_t w_read;
    logic        w_read_valid, w_read_ready;
    act_vec_t    act;
    logic        act_valid, act_ready, act_overflow;
    weight_mat_t w_new;
    logic        w_new_valid, w_new_ready, update_saturated;

    stream_fork #(.payload_t(layer_t), .N_OUT(3)) layer_splitter (
        .clk(clk), .rst(rst),
        .in_data  (layer_bw),         .in_valid (layer_bw_valid),   .in_ready(layer_bw_ready),
        .out_data (layer_copy),       .out_valid(layer_copy_valid), .out_ready(layer_copy_ready)
    );

    activation_path act_path (
        .clk(clk), .rst(rst),
        .layer    (layer_copy[2]),    .layer_valid(layer_copy_valid[2]),
        .layer_ready(layer_copy_ready[2]),
        .z        (z),                .z_valid  (z_valid),          .z_ready  (z_ready),
        .act      (act),              .act_valid(act_valid),        .act_ready(act_ready),
        .overflow (act_overflow)
    );

    weight_updater updater (
        .clk(clk), .rst(rst),
        .act      (act),              .act_valid  (act_valid),      .act_ready  (act_ready),
        .delta    (delta),            .delta_valid(delta_valid),    .delta_ready(delta_ready),
        .w        (w_copy[0]),        .w_valid    (w_copy_valid[0]), .w_ready   (w_copy_ready[0]),
        .result   (w_new),            .result_valid(w_new_valid),   .result_ready(w_new_ready),
        .saturated(update_saturated)
    );

    weight_memory weights (
        .clk(clk), .rst(rst),
        .bw_rd_addr(layer_copy[0]),   .bw_rd_addr_valid(layer_copy_valid[0]),
        .bw_rd_addr_ready(layer_copy_ready[0]),
        .bw_rd_data(w_read),          .bw_rd_data_valid(w_read_valid),
        .bw_rd_data_ready(w_read_ready),
        .bw_wr_addr(layer_copy[1]),   .bw_wr_addr_valid(layer_copy_valid[1]),
        .bw_wr_addr_ready(layer_copy_ready[1]),
        .bw_wr_data(w_new),           .bw_wr_data_valid(w_new_valid),
        .bw_wr_data_ready(w_new_ready),
        .fw_rd_addr(layer_fw),        .fw_rd_addr_valid(layer_fw_valid),
        .fw_rd_addr_ready(layer_fw_ready),
        .fw_rd_data(w_fw),            .fw_rd_data_valid(w_fw_valid),
        .fw_rd_data_ready(w_fw_ready)
    );

    stream_fork #(.payload_t(weight_mat_t), .N_OUT(2)) weight_splitter (
        .clk(clk), .rst(rst),
        .in_data  (w_read),           .in_valid (w_read_valid),     .in_ready (w_read_ready),
        .out_data (w_copy),           .out_valid(w_copy_valid),     .out_ready(w_copy_ready)
    );

    assign w_bw            = w_copy[1];
    assign w_bw_valid      = w_copy_valid[1];
    assign w_copy_ready[1] = w_bw_ready;

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (act_overflow || update_saturated) begin
            error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weight_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_memory import nn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    // backward read
    input  wire layer_t      bw_rd_addr,
    input  wire logic        bw_rd_addr_valid,
    output logic             bw_rd_addr_ready,
    output weight_mat_t      bw_rd_data,
    output logic             bw_rd_data_valid,
    input  wire logic        bw_rd_data_ready,
    // backward write
    input  wire layer_t      bw_wr_addr,
    input  wire logic        bw_wr_addr_valid,
    output logic             bw_wr_addr_ready,
    input  wire weight_mat_t bw_wr_data,
    input  wire logic        bw_wr_data_valid,
    output logic             bw_wr_data_ready,
    // forward read
    input  wire layer_t      fw_rd_addr,
    input  wire logic        fw_rd_addr_valid,
    output logic             fw_rd_addr_ready,
    output weight_mat_t      fw_rd_data,
    output logic             fw_rd_data_valid,
    input  wire logic        fw_rd_data_ready
);

    weight_mat_t mem [LAYER_NUM];
    logic        outstanding;
    logic        bw_rd_fire;
    logic        bw_wr_fire;
    logic        fw_rd_fire;

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////

    // no second read until the previous update is written back
    assign bw_rd_addr_ready = !outstanding && (!bw_rd_data_valid || bw_rd_data_ready);
    assign bw_rd_fire       = bw_rd_addr_valid && bw_rd_addr_ready;

    // address and data are written together
    assign bw_wr_fire       = bw_wr_addr_valid && bw_wr_data_valid;
    assign bw_wr_addr_ready = bw_wr_fire;
    assign bw_wr_data_ready = bw_wr_fire;

    assign fw_rd_addr_ready = !fw_rd_data_valid || fw_rd_data_ready;
    assign fw_rd_fire       = fw_rd_addr_valid && fw_rd_addr_ready;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // weights restart from zero on every reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LAYER_NUM; l++) begin
                mem[l] <= '0;
            end
        end else if (bw_wr_fire) begin
            mem[bw_wr_addr] <= bw_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (bw_rd_fire) begin
            bw_rd_data <= mem[bw_rd_addr];
        end
        if (fw_rd_fire) begin
            fw_rd_data <= mem[fw_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bw_rd_data_valid <= 1'b0;
            fw_rd_data_valid <= 1'b0;
            outstanding      <= 1'b0;
        end else begin
            if (bw_rd_fire) begin
                bw_rd_data_valid <= 1'b1;
            end else if (bw_rd_data_ready) begin
                bw_rd_data_valid <= 1'b0;
            end
            if (fw_rd_fire) begin
                fw_rd_data_valid <= 1'b1;
            end else if (fw_rd_data_ready) begin
                fw_rd_data_valid <= 1'b0;
            end
            if (bw_rd_fire) begin
                outstanding <= 1'b1;
            end else if (bw_wr_fire) begin
                outstanding <= 1'b0;
            end
        end
    end

    // every write-back pairs with an earlier backward read
    write_after_read: assert property (@(posedge clk) disable iff (rst)
        bw_wr_fire |-> outstanding);

endmodule

`default_nettype wire

// ==== hdl/weight_updater.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_updater import nn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire act_vec_t    act,
    input  wire logic        act_valid,
    output logic             act_ready,
    input  wire delta_vec_t  delta,
    input  wire logic        delta_valid,
    output logic             delta_ready,
    input  wire weight_mat_t w,
    input  wire logic        w_valid,
    output logic             w_ready,
    output weight_mat_t      result,
    output logic             result_valid,
    input  wire logic        result_ready,
    output logic             saturated
);

    weight_mat_t        result_next;
    logic               sat_next;
    logic               sat_q;
    logic               join_fire;
    logic signed [31:0] diff;

    // w - ((delta * a) >>> shift) in 32 bits so it never wraps
    function automatic logic signed [31:0] raw_update(weight_t w_old, delta_t d, act_t a);
        logic signed [31:0] prod;
        prod = d * a;
        return w_old - (prod >>> LEARNING_RATE_SHIFT);
    endfunction

    assign join_fire   = act_valid && delta_valid && w_valid && (!result_valid || result_ready);
    assign act_ready   = join_fire;
    assign delta_ready = join_fire;
    assign w_ready     = join_fire;

    always_comb begin
        result_next = '0;
        sat_next    = 1'b0;
        diff        = '0;
        for (int i = 0; i < NEURON_NUM; i++) begin
            for (int j = 0; j < NEURON_NUM; j++) begin
                diff = raw_update(w[i][j], delta[i], act[j]);
                if (diff > WEIGHT_MAX) begin
                    result_next[i][j] = weight_t'(WEIGHT_MAX);
                    sat_next          = 1'b1;
                end else if (diff < WEIGHT_MIN) begin
                    result_next[i][j] = weight_t'(WEIGHT_MIN);
                    sat_next          = 1'b1;
                end else begin
                    result_next[i][j] = weight_t'(diff);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            result <= result_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            sat_q        <= 1'b0;
        end else if (join_fire) begin
            result_valid <= 1'b1;
            sat_q        <= sat_next;
        end else if (result_ready) begin
            result_valid <= 1'b0;
            sat_q        <= 1'b0;
        end
    end

    assign saturated = result_valid && result_ready && sat_q;

    // the three operands of one update are consumed as a unit
    join_readies: assert property (@(posedge clk) disable iff (rst)
        act_ready == delta_ready && delta_ready == w_ready);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    input  wire logic rst_req,
    output logic      clk,
    output logic      rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // reset at start, and again on each request
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        forever begin
            @(posedge rst_req);
            @(posedge clk);
            #2;
            rst = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #2;
            rst = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/weight_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_controller_tb import nn_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int HIDDEN_OPS     = 24;
    localparam int INPUT_OPS      = 12;
    localparam int SAT_OPS_MAX    = 8;
    // backward ops plus three sweeps of forward reads
    localparam int TOTAL_OPS      = HIDDEN_OPS + INPUT_OPS + 1 + SAT_OPS_MAX + 3 * LAYER_NUM;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_OPS + 1000;

    logic        clk;
    logic        rst;
    logic        rst_req;
    layer_t      layer_bw;
    logic        layer_bw_valid;
    logic        layer_bw_ready;
    layer_t      layer_fw;
    logic        layer_fw_valid;
    logic        layer_fw_ready;
    z_vec_t      z;
    logic        z_valid;
    logic        z_ready;
    delta_vec_t  delta;
    logic        delta_valid;
    logic        delta_ready;
    weight_mat_t w_fw;
    logic        w_fw_valid;
    logic        w_fw_ready;
    weight_mat_t w_bw;
    logic        w_bw_valid;
    logic        w_bw_ready;
    logic        error;

    integer seed = 36;
    integer mismatches = 0;
    integer failures = 0;
    integer issued_ops = 0;
    integer bw_transfers = 0;

    // reference model state
    integer      model_w [LAYER_NUM][NEURON_NUM][NEURON_NUM];
    logic        exp_error;
    integer      op_z [NEURON_NUM];
    integer      op_d [NEURON_NUM];
    weight_mat_t exp_bw [$];
    weight_mat_t exp_fw [$];
    weight_mat_t bw_expected;
    weight_mat_t fw_expected;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen (
        .rst_req(rst_req),
        .clk    (clk),
        .rst    (rst)
    );

    weight_controller UUT (
        .clk(clk), .rst(rst),
        .layer_bw(layer_bw), .layer_bw_valid(layer_bw_valid), .layer_bw_ready(layer_bw_ready),
        .layer_fw(layer_fw), .layer_fw_valid(layer_fw_valid), .layer_fw_ready(layer_fw_ready),
        .z(z), .z_valid(z_valid), .z_ready(z_ready),
        .delta(delta), .delta_valid(delta_valid), .delta_ready(delta_ready),
        .w_fw(w_fw), .w_fw_valid(w_fw_valid), .w_fw_ready(w_fw_ready),
        .w_bw(w_bw), .w_bw_valid(w_bw_valid), .w_bw_ready(w_bw_ready),
        .error(error)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic clear_model();
        for (int l = 0; l < LAYER_NUM; l++) begin
            for (int i = 0; i < NEURON_NUM; i++) begin
                for (int j = 0; j < NEURON_NUM; j++) begin
                    model_w[l][i][j] = 0;
                end
            end
        end
        exp_error = 1'b0;
    endtask

    function automatic weight_mat_t model_matrix(input layer_t layer);
        weight_mat_t m;
        for (int i = 0; i < NEURON_NUM; i++) begin
            for (int j = 0; j < NEURON_NUM; j++) begin
                m[i][j] = weight_t'(model_w[layer][i][j]);
            end
        end
        return m;
    endfunction

    // applies one backward op from op_z and op_d
    task automatic model_backward(input layer_t layer);
        integer a [NEURON_NUM];
        integer t;
        integer nw;
        for (int j = 0; j < NEURON_NUM; j++) begin
            if (layer == 0) begin
                // low ACT_WIDTH bits, read back as signed
                t = op_z[j] & ((1 << ACT_WIDTH) - 1);
                if (t > ACT_MAX) begin
                    t = t - (1 << ACT_WIDTH);
                end
                if (op_z[j] > ACT_MAX || op_z[j] < ACT_MIN) begin
                    exp_error = 1'b1;
                end
                a[j] = t;
            end else begin
                a[j] = (op_z[j] >>> SIGMOID_SHIFT) + SIGMOID_OFFSET;
            end
        end
        for (int i = 0; i < NEURON_NUM; i++) begin
            for (int j = 0; j < NEURON_NUM; j++) begin
                nw = model_w[layer][i][j] - ((op_d[i] * a[j]) >>> LEARNING_RATE_SHIFT);
                if (nw > WEIGHT_MAX) begin
                    nw = WEIGHT_MAX;
                    exp_error = 1'b1;
                end else if (nw < WEIGHT_MIN) begin
                    nw = WEIGHT_MIN;
                    exp_error = 1'b1;
                end
                model_w[layer][i][j] = nw;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // one clock, then drop valids that transferred and redraw the readies
    task automatic next_cycle();
        logic layer_fire;
        logic z_fire;
        logic delta_fire;
        logic fw_fire;
        @(posedge clk);
        layer_fire = layer_bw_valid && layer_bw_ready;
        z_fire     = z_valid && z_ready;
        delta_fire = delta_valid && delta_ready;
        fw_fire    = layer_fw_valid && layer_fw_ready;
        #(DRIVE_DELAY);
        if (layer_fire) begin
            layer_bw_valid = 1'b0;
        end
        if (z_fire) begin
            z_valid = 1'b0;
        end
        if (delta_fire) begin
            delta_valid = 1'b0;
        end
        if (fw_fire) begin
            layer_fw_valid = 1'b0;
        end
        w_bw_ready = ($random(seed) & 3) != 0;
        w_fw_ready = ($random(seed) & 1) != 0;
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            mismatches++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_idle();
        check_bit("w_bw_valid", w_bw_valid, 1'b0);
        check_bit("w_fw_valid", w_fw_valid, 1'b0);
        check_bit("error", error, 1'b0);
    endtask

    task automatic apply_reset();
        rst_req = 1'b1;
        @(negedge rst);
        rst_req = 1'b0;
        clear_model();
        check_idle();
    endtask

    task automatic pick_hidden_op();
        for (int k = 0; k < NEURON_NUM; k++) begin
            op_z[k] = $random(seed) % (1 << (Z_WIDTH - 1));
            op_d[k] = $random(seed) % 16;
        end
    endtask

    // z kept inside the signed activation range
    task automatic pick_input_op();
        for (int k = 0; k < NEURON_NUM; k++) begin
            op_z[k] = $random(seed) % (1 << (ACT_WIDTH - 1));
            op_d[k] = $random(seed) % 16;
        end
    endtask

    task automatic issue_backward(input layer_t layer);
        exp_bw.push_back(model_matrix(layer));
        model_backward(layer);
        issued_ops++;
        layer_bw = layer;
        for (int k = 0; k < NEURON_NUM; k++) begin
            z[k]     = z_cell_t'(op_z[k]);
            delta[k] = delta_t'(op_d[k]);
        end
        layer_bw_valid = 1'b1;
        z_valid        = 1'b1;
        delta_valid    = 1'b1;
        while (layer_bw_valid || z_valid || delta_valid) begin
            next_cycle();
        end
    endtask

    task automatic drain();
        while (exp_bw.size() != 0) begin
            next_cycle();
        end
        // write-back lands one cycle after the updater join
        next_cycle();
        check_bit("error", error, exp_error);
    endtask

    task automatic read_forward(input layer_t layer);
        exp_fw.push_back(model_matrix(layer));
        layer_fw       = layer;
        layer_fw_valid = 1'b1;
        while (layer_fw_valid || exp_fw.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic read_all_layers();
        for (int l = 0; l < LAYER_NUM; l++) begin
            read_forward(layer_t'(l));
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d backward ops seen",
                 mismatches, failures, bw_transfers, issued_ops);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitors
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && w_bw_valid && w_bw_ready) begin
            bw_transfers++;
            assert (exp_bw.size() != 0) else begin
                failures++;
                $display("Unexpected w_bw transfer at %0t with no backward op pending", $time);
            end
            if (exp_bw.size() != 0) begin
                bw_expected = exp_bw.pop_front();
                assert (w_bw == bw_expected) else begin
                    mismatches++;
                    $display("Mismatch at %0t: w_bw is %h, expected %h",
                             $time, w_bw, bw_expected);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && w_fw_valid && w_fw_ready) begin
            assert (exp_fw.size() != 0) else begin
                failures++;
                $display("Unexpected w_fw transfer at %0t with no forward read pending", $time);
            end
            if (exp_fw.size() != 0) begin
                fw_expected = exp_fw.pop_front();
                assert (w_fw == fw_expected) else begin
                    mismatches++;
                    $display("Mismatch at %0t: w_fw is %h, expected %h",
                             $time, w_fw, fw_expected);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        rst_req        = 1'b0;
        layer_bw       = '0;
        layer_bw_valid = 1'b0;
        layer_fw       = '0;
        layer_fw_valid = 1'b0;
        z              = '0;
        z_valid        = 1'b0;
        delta          = '0;
        delta_valid    = 1'b0;
        w_fw_ready     = 1'b1;
        w_bw_ready     = 1'b1;
        clear_model();
        @(negedge rst);

        // idle outputs and zero weights after reset
        check_idle();
        read_all_layers();

        // hidden layers under random back-pressure
        for (int k = 0; k < HIDDEN_OPS; k++) begin
            pick_hidden_op();
            issue_backward(layer_t'(1 + {$random(seed)} % 3));
        end
        drain();
        read_all_layers();

        // input layer with truncated z
        for (int k = 0; k < INPUT_OPS; k++) begin
            pick_input_op();
            issue_backward(layer_t'(0));
        end
        drain();
        read_all_layers();
        check_bit("error", error, 1'b0);

        // z cell too wide for the activation
        apply_reset();
        pick_input_op();
        op_z[1] = ACT_MAX + 45;
        issue_backward(layer_t'(0));
        drain();
        check_bit("error", error, 1'b1);

        // full-range deltas until the weights clamp
        apply_reset();
        for (int k = 0; k < SAT_OPS_MAX && !exp_error; k++) begin
            for (int n = 0; n < NEURON_NUM; n++) begin
                op_z[n] = (1 << (Z_WIDTH - 1)) - 1;
                op_d[n] = -(1 << (DELTA_WIDTH - 1));
            end
            issue_backward(layer_t'(1));
            drain();
        end
        assert (exp_error) else begin
            failures++;
            $display("Saturation was not reached within %0d full-range updates", SAT_OPS_MAX);
        end
        check_bit("error", error, 1'b1);

        assert (bw_transfers == issued_ops) else begin
            failures++;
            $display("Lost or duplicated w_bw transfers: %0d seen for %0d issued ops",
                     bw_transfers, issued_ops);
        end

        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run was still busy after %0d cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== weight_controller.f ====
hdl/nn_pkg.sv
hdl/stream_fork.sv
hdl/activation_path.sv
hdl/weight_updater.sv
hdl/weight_memory.sv
hdl/weight_controller.sv
tb/tb_clock_gen.sv
tb/weight_controller_tb.sv
